//--- rrag_pkg.sv
package rrag_pkg;

    localparam int NUM_REGS  = 8;
    // segment base lands in bits 31:16 of the linear address.
    localparam int SEG_SHIFT = 16;

    // data and address word.
    typedef logic [31:0] word_t;
    // segment base value.
    typedef logic [15:0] seg_t;
    // selects a general or a segment register.
    typedef logic [2:0] reg_idx_t;
    // index shift, x1 x2 x4 x8.
    typedef logic [1:0] scale_t;
    // operand size code, 1 2 4 or 8 bytes.
    typedef logic [1:0] opsize_t;

    // access size in bytes for an operand size code.
    function automatic word_t opsize_bytes(input opsize_t size);
        return word_t'(1) << size;
    endfunction

endpackage

//--- rrag_flow_pkg.sv
package rrag_flow_pkg;

    // entries in the operand queue, also the initial credit count.
    localparam int QUEUE_DEPTH = 4;

    // holds 0 to QUEUE_DEPTH.
    typedef logic [2:0] credit_t;

endpackage

//--- uop_if.sv
interface uop_if import rrag_pkg::*; ();

    logic     push;
    word_t    base_val;
    word_t    index_val;
    scale_t   scale;
    word_t    disp;
    seg_t     seg_val;
    opsize_t  opsize;
    logic     dest_ld;
    reg_idx_t dest;
    // one-cycle pulse back toward the sender.
    logic     credit;

    modport src (
        output push,
        output base_val,
        output index_val,
        output scale,
        output disp,
        output seg_val,
        output opsize,
        output dest_ld,
        output dest,
        input  credit
    );

    modport dst (
        input  push,
        input  base_val,
        input  index_val,
        input  scale,
        input  disp,
        input  seg_val,
        input  opsize,
        input  dest_ld,
        input  dest,
        output credit
    );

endinterface

//--- reg_file.sv
module reg_file import rrag_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                wb_en,
    input  logic                wb_seg,
    input  reg_idx_t            wb_addr,
    input  word_t               wb_data,
    input  reg_idx_t            rd_base,
    input  reg_idx_t            rd_index,
    input  reg_idx_t            rd_seg,
    input  logic                mark_en,
    input  reg_idx_t            mark_idx,
    output word_t               base_val,
    output word_t               index_val,
    output seg_t                seg_val,
    output logic [NUM_REGS-1:0] pending
);

    word_t gpr [NUM_REGS];
    seg_t  sgr [NUM_REGS];

    // one write port shared by both arrays.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                gpr[i] <= '0;
                sgr[i] <= '0;
            end
        end else if (wb_en) begin
            if (wb_seg) begin
                sgr[wb_addr] <= wb_data[15:0];
            end else begin
                gpr[wb_addr] <= wb_data;
            end
        end
    end

    // scoreboard, a new mark overrides a clear on the same edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            if (wb_en && !wb_seg) begin
                pending[wb_addr] <= 1'b0;
            end
            if (mark_en) begin
                pending[mark_idx] <= 1'b1;
            end
        end
    end

    // no bypass, writes show up the cycle after.
    assign base_val  = gpr[rd_base];
    assign index_val = gpr[rd_index];
    assign seg_val   = sgr[rd_seg];

endmodule

//--- operand_read.sv
module operand_read import rrag_pkg::*, rrag_flow_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  reg_idx_t in_base,
    input  reg_idx_t in_index,
    input  reg_idx_t in_seg,
    input  scale_t   in_scale,
    input  word_t    in_disp,
    input  opsize_t  in_opsize,
    input  logic     in_use_base,
    input  logic     in_use_index,
    input  logic     in_dest_ld,
    input  reg_idx_t in_dest,

    input  logic     wb_en,
    input  logic     wb_seg,
    input  reg_idx_t wb_addr,
    input  word_t    wb_data,

    uop_if.src       q
);

    word_t               base_val;
    word_t               index_val;
    seg_t                seg_val;
    logic [NUM_REGS-1:0] pending;
    credit_t             credits;
    logic                src_busy;
    logic                accept;

    reg_file rf_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_en     (wb_en),
        .wb_seg    (wb_seg),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .rd_base   (in_base),
        .rd_index  (in_index),
        .rd_seg    (in_seg),
        .mark_en   (accept && in_dest_ld),
        .mark_idx  (in_dest),
        .base_val  (base_val),
        .index_val (index_val),
        .seg_val   (seg_val),
        .pending   (pending)
    );

    // only sources actually used can hold the micro-op.
    assign src_busy = (in_use_base && pending[in_base]) ||
                      (in_use_index && pending[in_index]);

    assign in_ready = !src_busy && (credits != '0);
    assign accept   = in_valid && in_ready;

    // the credit is taken at acceptance, so the push that follows always has one.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= credit_t'(QUEUE_DEPTH);
        end else begin
            credits <= credits - credit_t'(accept) + credit_t'(q.credit);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q.push <= 1'b0;
        end else begin
            q.push <= accept;
        end
    end

    // unused base or index go in as zero.
    always_ff @(posedge clk) begin
        if (accept) begin
            q.base_val  <= in_use_base ? base_val : '0;
            q.index_val <= in_use_index ? index_val : '0;
            q.scale     <= in_scale;
            q.disp      <= in_disp;
            q.seg_val   <= seg_val;
            q.opsize    <= in_opsize;
            q.dest_ld   <= in_dest_ld;
            q.dest      <= in_dest;
        end
    end

endmodule

//--- operand_queue.sv
module operand_queue import rrag_pkg::*, rrag_flow_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    uop_if.dst   wr,
    uop_if.src   rd
);

    word_t    base_mem  [QUEUE_DEPTH];
    word_t    index_mem [QUEUE_DEPTH];
    scale_t   scale_mem [QUEUE_DEPTH];
    word_t    disp_mem  [QUEUE_DEPTH];
    seg_t     seg_mem   [QUEUE_DEPTH];
    opsize_t  size_mem  [QUEUE_DEPTH];
    logic     ld_mem    [QUEUE_DEPTH];
    reg_idx_t dest_mem  [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
    credit_t                        fill;
    logic                           pop;

    // the pop pulse doubles as the returned credit.
    assign pop       = rd.credit;
    assign wr.credit = pop;
    assign rd.push   = (fill != '0);

    // credits keep the sender from pushing into a full queue.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (wr.push) begin
                wr_ptr <= (int'(wr_ptr) == QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + credit_t'(wr.push) - credit_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (wr.push) begin
            base_mem[wr_ptr]  <= wr.base_val;
            index_mem[wr_ptr] <= wr.index_val;
            scale_mem[wr_ptr] <= wr.scale;
            disp_mem[wr_ptr]  <= wr.disp;
            seg_mem[wr_ptr]   <= wr.seg_val;
            size_mem[wr_ptr]  <= wr.opsize;
            ld_mem[wr_ptr]    <= wr.dest_ld;
            dest_mem[wr_ptr]  <= wr.dest;
        end
    end

    // head entry.
    assign rd.base_val  = base_mem[rd_ptr];
    assign rd.index_val = index_mem[rd_ptr];
    assign rd.scale     = scale_mem[rd_ptr];
    assign rd.disp      = disp_mem[rd_ptr];
    assign rd.seg_val   = seg_mem[rd_ptr];
    assign rd.opsize    = size_mem[rd_ptr];
    assign rd.dest_ld   = ld_mem[rd_ptr];
    assign rd.dest      = dest_mem[rd_ptr];

endmodule

//--- addr_gen.sv
module addr_gen import rrag_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     out_ready,
    uop_if.dst       q,
    output logic     out_valid,
    output word_t    out_lin_addr,
    output word_t    out_end_addr,
    output logic     out_dest_ld,
    output reg_idx_t out_dest
);

    word_t offset;
    word_t seg_base;
    word_t lin_addr;
    word_t end_addr;
    logic  pop;

    // take the head when the output slot is free or leaving this cycle.
    assign pop      = q.push && (!out_valid || out_ready);
    assign q.credit = pop;

    // base and index arrive already zeroed when unused.
    assign offset   = q.base_val + (q.index_val << q.scale) + q.disp;
    assign seg_base = word_t'(q.seg_val) << SEG_SHIFT;
    assign lin_addr = offset + seg_base;
    // last byte touched, wraps at 2^32.
    assign end_addr = lin_addr + opsize_bytes(q.opsize) - word_t'(1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // held while out_valid waits on out_ready.
    always_ff @(posedge clk) begin
        if (pop) begin
            out_lin_addr <= lin_addr;
            out_end_addr <= end_addr;
            out_dest_ld  <= q.dest_ld;
            out_dest     <= q.dest;
        end
    end

endmodule

//--- rrag_top.sv
module rrag_top import rrag_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  reg_idx_t in_base,
    input  reg_idx_t in_index,
    input  reg_idx_t in_seg,
    input  scale_t   in_scale,
    input  word_t    in_disp,
    input  opsize_t  in_opsize,
    input  logic     in_use_base,
    input  logic     in_use_index,
    input  logic     in_dest_ld,
    input  reg_idx_t in_dest,

    input  logic     wb_en,
    input  logic     wb_seg,
    input  reg_idx_t wb_addr,
    input  word_t    wb_data,

    output logic     out_valid,
    input  logic     out_ready,
    output word_t    out_lin_addr,
    output word_t    out_end_addr,
    output logic     out_dest_ld,
    output reg_idx_t out_dest
);

    uop_if rd2q ();
    uop_if q2ag ();

    operand_read rd_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_base      (in_base),
        .in_index     (in_index),
        .in_seg       (in_seg),
        .in_scale     (in_scale),
        .in_disp      (in_disp),
        .in_opsize    (in_opsize),
        .in_use_base  (in_use_base),
        .in_use_index (in_use_index),
        .in_dest_ld   (in_dest_ld),
        .in_dest      (in_dest),
        .wb_en        (wb_en),
        .wb_seg       (wb_seg),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .q            (rd2q)
    );

    operand_queue q_i (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (rd2q),
        .rd     (q2ag)
    );

    addr_gen ag_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .out_ready    (out_ready),
        .q            (q2ag),
        .out_valid    (out_valid),
        .out_lin_addr (out_lin_addr),
        .out_end_addr (out_end_addr),
        .out_dest_ld  (out_dest_ld),
        .out_dest     (out_dest)
    );

endmodule

//--- rrag_tb_vectors.svh
`ifndef RRAG_TB_VECTORS_SVH
`define RRAG_TB_VECTORS_SVH

// kind 0 is a micro-op, 1 a general register write, 2 a segment register write.
// a write uses base as the register and disp as the data.
typedef struct packed {
    logic [1:0] kind;
    reg_idx_t   base;
    reg_idx_t   index;
    reg_idx_t   seg;
    scale_t     scale;
    opsize_t    opsize;
    logic       use_base;
    logic       use_index;
    logic       dest_ld;
    reg_idx_t   dest;
    word_t      disp;
    word_t      exp_lin;
    word_t      exp_end;
} vec_t;

localparam int NUM_VECTORS = 14;

// kind base index seg scale opsize use_base use_index dest_ld dest, then disp lin end.
localparam vec_t VECTORS [NUM_VECTORS] = '{
    '{2'd0, 3'd0, 3'd0, 3'd0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0, 3'd0,
      32'h0000_0100, 32'h0000_0100, 32'h0000_0100},
    '{2'd0, 3'd1, 3'd2, 3'd0, 2'd3, 2'd1, 1'b1, 1'b1, 1'b0, 3'd0,
      32'h0000_2000, 32'h0000_2000, 32'h0000_2001},
    '{2'd1, 3'd1, 3'd0, 3'd0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0, 3'd0,
      32'h1000_0000, 32'h0000_0000, 32'h0000_0000},
    '{2'd1, 3'd2, 3'd0, 3'd0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0, 3'd0,
      32'h0000_0010, 32'h0000_0000, 32'h0000_0000},
    '{2'd2, 3'd1, 3'd0, 3'd0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0, 3'd0,
      32'h0000_0003, 32'h0000_0000, 32'h0000_0000},
    '{2'd1, 3'd3, 3'd0, 3'd0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0, 3'd0,
      32'hFFFF_FFF0, 32'h0000_0000, 32'h0000_0000},
    '{2'd2, 3'd2, 3'd0, 3'd0, 2'd0, 2'd0, 1'b0, 1'b0, 1'b0, 3'd0,
      32'h1234_ABCD, 32'h0000_0000, 32'h0000_0000},
    '{2'd0, 3'd1, 3'd2, 3'd0, 2'd0, 2'd2, 1'b1, 1'b0, 1'b1, 3'd5,
      32'h0000_0004, 32'h1000_0004, 32'h1000_0007},
    '{2'd0, 3'd3, 3'd2, 3'd0, 2'd0, 2'd3, 1'b0, 1'b1, 1'b0, 3'd0,
      32'h0000_0000, 32'h0000_0010, 32'h0000_0017},
    '{2'd0, 3'd1, 3'd2, 3'd1, 2'd1, 2'd2, 1'b1, 1'b1, 1'b1, 3'd6,
      32'h0000_0008, 32'h1003_0028, 32'h1003_002B},
    '{2'd0, 3'd1, 3'd2, 3'd2, 2'd2, 2'd1, 1'b0, 1'b1, 1'b0, 3'd0,
      32'h0000_0000, 32'hABCD_0040, 32'hABCD_0041},
    '{2'd0, 3'd3, 3'd0, 3'd0, 2'd0, 2'd0, 1'b1, 1'b0, 1'b0, 3'd0,
      32'h0000_0020, 32'h0000_0010, 32'h0000_0010},
    '{2'd0, 3'd3, 3'd0, 3'd0, 2'd0, 2'd3, 1'b1, 1'b0, 1'b1, 3'd7,
      32'h0000_000C, 32'hFFFF_FFFC, 32'h0000_0003},
    '{2'd0, 3'd3, 3'd1, 3'd2, 2'd3, 2'd2, 1'b1, 1'b1, 1'b0, 3'd0,
      32'h0000_0100, 32'h2BCD_00F0, 32'h2BCD_00F3}
};

`endif

//--- rrag_tb.sv
module rrag_tb import rrag_pkg::*, rrag_flow_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

`include "rrag_tb_vectors.svh"

    typedef struct packed {
        word_t    lin;
        word_t    end_addr;
        logic     dest_ld;
        reg_idx_t dest;
    } exp_t;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    logic     in_ready;
    reg_idx_t in_base;
    reg_idx_t in_index;
    reg_idx_t in_seg;
    scale_t   in_scale;
    word_t    in_disp;
    opsize_t  in_opsize;
    logic     in_use_base;
    logic     in_use_index;
    logic     in_dest_ld;
    reg_idx_t in_dest;
    logic     wb_en;
    logic     wb_seg;
    reg_idx_t wb_addr;
    word_t    wb_data;
    logic     out_valid;
    logic     out_ready;
    word_t    out_lin_addr;
    word_t    out_end_addr;
    logic     out_dest_ld;
    reg_idx_t out_dest;

    word_t       model_gpr [NUM_REGS];
    seg_t        model_sgr [NUM_REGS];
    exp_t        expected_q [$];
    exp_t        seen;
    int          errors = 0;
    integer      seed = 32'he10;
    integer      ready_seed = 32'he10;
    logic [1:0]  ready_mode = 2'd0;
    logic [31:0] ready_rnd;

    rrag_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // mode 0 holds out_ready high, 1 holds it low, 2 randomizes it.
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #0.5;
            ready_rnd = $random(ready_seed);
            case (ready_mode)
                2'd0:    out_ready = 1'b1;
                2'd1:    out_ready = 1'b0;
                default: out_ready = ready_rnd[0];
            endcase
        end
    end

    task automatic check_val(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic exp_t model_exp(input vec_t v);
        exp_t  e;
        word_t offset;
        offset = v.disp;
        if (v.use_base) offset = offset + model_gpr[v.base];
        if (v.use_index) offset = offset + (model_gpr[v.index] << v.scale);
        e.lin      = offset + (word_t'(model_sgr[v.seg]) << SEG_SHIFT);
        e.end_addr = e.lin + (word_t'(1) << v.opsize) - word_t'(1);
        e.dest_ld  = v.dest_ld;
        e.dest     = v.dest;
        return e;
    endfunction

    task automatic set_fields(input vec_t v);
        in_base      = v.base;
        in_index     = v.index;
        in_seg       = v.seg;
        in_scale     = v.scale;
        in_disp      = v.disp;
        in_opsize    = v.opsize;
        in_use_base  = v.use_base;
        in_use_index = v.use_index;
        in_dest_ld   = v.dest_ld;
        in_dest      = v.dest;
    endtask

    // in_valid is already high, the transfer is on the edge after the sample.
    task automatic wait_accept(input exp_t e);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < 50) begin
            @(negedge clk);
            if (in_ready) begin
                expected_q.push_back(e);
                done = 1'b1;
            end
            cycles++;
        end
        if (!done) begin
            $display("timeout: a micro-op was never accepted");
            errors++;
        end
        @(posedge clk);
        #0.5;
        in_valid = 1'b0;
    endtask

    task automatic send_uop(input vec_t v, input exp_t e);
        set_fields(v);
        in_valid = 1'b1;
        wait_accept(e);
    endtask

    task automatic write_reg(input logic seg, input reg_idx_t addr, input word_t data);
        wb_en   = 1'b1;
        wb_seg  = seg;
        wb_addr = addr;
        wb_data = data;
        if (seg) model_sgr[addr] = data[15:0];
        else model_gpr[addr] = data;
        @(posedge clk);
        #0.5;
        wb_en = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < 200) begin
            @(posedge clk);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("timeout: %0d results never came out", expected_q.size());
            errors++;
        end
        @(posedge clk);
        #0.5;
    endtask

    // output transfers happen on the edge after this sample.
    always @(negedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("an output appeared with no micro-op outstanding");
                errors++;
            end else begin
                seen = expected_q.pop_front();
                check_val("out_lin_addr", out_lin_addr, seen.lin);
                check_val("out_end_addr", out_end_addr, seen.end_addr);
                check_val("out_dest_ld", word_t'(out_dest_ld), word_t'(seen.dest_ld));
                check_val("out_dest", word_t'(out_dest), word_t'(seen.dest));
            end
        end
    end

    initial begin
        vec_t        v;
        exp_t        e;
        logic [31:0] r1;
        logic [31:0] r2;
        int          accepted;
        logic        stalled;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        set_fields('0);
        wb_en   = 1'b0;
        wb_seg  = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_gpr[i] = '0;
            model_sgr[i] = '0;
        end
        repeat (10) @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        @(negedge clk);
        check_val("out_valid", word_t'(out_valid), 32'h0);
        check_val("in_ready", word_t'(in_ready), 32'h1);
        @(posedge clk);
        #0.5;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            v = VECTORS[i];
            if (v.kind == 2'd0) begin
                e.lin      = v.exp_lin;
                e.end_addr = v.exp_end;
                e.dest_ld  = v.dest_ld;
                e.dest     = v.dest;
                send_uop(v, e);
            end else begin
                write_reg(v.kind == 2'd2, v.base, v.disp);
            end
        end
        wait_drain();

        // second micro-op reads r4, which the first one loads.
        v = '0;
        v.disp    = 32'h0000_0040;
        v.opsize  = 2'd2;
        v.dest_ld = 1'b1;
        v.dest    = 3'd4;
        send_uop(v, model_exp(v));
        v = '0;
        v.use_base = 1'b1;
        v.base     = 3'd4;
        v.disp     = 32'h0000_0008;
        set_fields(v);
        in_valid = 1'b1;
        repeat (6) begin
            @(negedge clk);
            check_val("in_ready", word_t'(in_ready), 32'h0);
        end
        @(posedge clk);
        #0.5;
        write_reg(1'b0, 3'd4, 32'h0000_5000);
        wait_accept(model_exp(v));
        wait_drain();

        // output stalled, the queue and the output register fill up.
        ready_mode = 2'd1;
        @(posedge clk);
        #0.5;
        accepted = 0;
        stalled  = 1'b0;
        v = '0;
        v.use_index = 1'b1;
        v.index     = 3'd2;
        v.scale     = 2'd1;
        v.opsize    = 2'd1;
        v.dest_ld   = 1'b1;
        in_valid    = 1'b1;
        while (!stalled && accepted < 20) begin
            v.disp = word_t'(accepted) << 4;
            v.dest = {1'b1, accepted[1:0]};
            set_fields(v);
            @(negedge clk);
            if (in_ready) begin
                expected_q.push_back(model_exp(v));
                accepted++;
            end else begin
                stalled = 1'b1;
            end
            @(posedge clk);
            #0.5;
        end
        in_valid = 1'b0;
        if (!stalled) begin
            $display("timeout: in_ready never fell while out_ready was low");
            errors++;
        end
        check_val("accepted", word_t'(accepted), word_t'(QUEUE_DEPTH + 1));
        ready_mode = 2'd0;
        wait_drain();

        // sources stay in r0 to r3, destinations in r4 to r7.
        ready_mode = 2'd2;
        for (int n = 0; n < 40; n++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            v = '0;
            v.base      = {1'b0, r1[1:0]};
            v.index     = {1'b0, r1[3:2]};
            v.seg       = r1[6:4];
            v.scale     = r1[8:7];
            v.opsize    = r1[10:9];
            v.use_base  = r1[11];
            v.use_index = r1[12];
            v.dest_ld   = r1[13];
            v.dest      = {1'b1, r1[15:14]};
            v.disp      = r2;
            send_uop(v, model_exp(v));
        end
        wait_drain();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- rrag_top.f
+incdir+.
rrag_pkg.sv
rrag_flow_pkg.sv
uop_if.sv
reg_file.sv
operand_read.sv
operand_queue.sv
addr_gen.sv
rrag_top.sv
rrag_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the fail message in the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module rrag_tb -f rrag_top.f -o rrag_sim \
    && ./obj_dir/rrag_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
